// ==== verilog/kcpu_pkg.sv ====
package kcpu_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [23:0] baddr_t;   // Full bus address, top byte always zero

    // 6809 encodings
    localparam byte_t OP_NOP     = 8'h12;
    localparam byte_t OP_LDA_IMM = 8'h86;
    localparam byte_t OP_LDA_EXT = 8'hb6;
    localparam byte_t OP_LDB_IMM = 8'hc6;
    localparam byte_t OP_LDX_IMM = 8'h8e;
    localparam byte_t OP_STA_EXT = 8'hb7;
    localparam byte_t OP_STB_EXT = 8'hf7;
    localparam byte_t OP_ADDA    = 8'h8b;
    localparam byte_t OP_SUBA    = 8'h80;
    localparam byte_t OP_ANDA    = 8'h84;
    // Indexed forms imply ,X+ and take no postbyte
    localparam byte_t OP_LDA_IDX = 8'ha6;
    localparam byte_t OP_STA_IDX = 8'ha7;
    localparam byte_t OP_BRA     = 8'h20;
    localparam byte_t OP_BCS     = 8'h25;
    localparam byte_t OP_BNE     = 8'h26;
    localparam byte_t OP_BEQ     = 8'h27;

    // Condition code bits
    localparam int CC_C = 0;
    localparam int CC_V = 1;
    localparam int CC_Z = 2;
    localparam int CC_N = 3;

    typedef enum logic [1:0] {
        ALU_PASS,   // Result is the memory operand
        ALU_ADD,
        ALU_SUB,
        ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_OPND,     // First step after the opcode, decodes it
        ST_OPND_LO,
        ST_EXEC,
        ST_WRITE,
        ST_TRAP
    } cpu_state_e;

    typedef enum logic [1:0] {
        AS_PC,
        AS_EXT,      // Captured 16-bit operand
        AS_X
    } asel_e;

    typedef struct packed {
        asel_e   asel;
        logic    we;
        logic    fetch;     // Capture opcode
        logic    opd;       // Capture high operand byte
        logic    opd_lo;    // Capture low operand byte
        alu_op_e alu_op;
        logic    up_a;
        logic    up_b;
        logic    up_x;
        logic    up_cc;
        logic    inc_pc;
        logic    incx;
        logic    branch;    // Add signed offset to PC
        logic    src_b;     // Write data from B
    } ctrl_t;

    typedef struct packed {
        byte_t op;
        byte_t mdata_hi;
        byte_t mdata_lo;
    } mem_t;

endpackage

// ==== verilog/kcpu_alu.sv ====
module kcpu_alu (
    input  kcpu_pkg::alu_op_e alu_op,
    input  kcpu_pkg::byte_t   opnd0,
    input  kcpu_pkg::byte_t   opnd1,
    input  kcpu_pkg::byte_t   cc_in,
    output kcpu_pkg::byte_t   rslt,
    output kcpu_pkg::byte_t   cc_out
);

    logic [8:0] sum;

    always_comb begin
        sum    = '0;
        rslt   = opnd1;
        cc_out = cc_in;
        case (alu_op)
            kcpu_pkg::ALU_ADD: begin
                sum  = {1'b0, opnd0} + {1'b0, opnd1};
                rslt = sum[7:0];
                cc_out[kcpu_pkg::CC_C] = sum[8];
                // Same-sign operands, result sign flipped
                cc_out[kcpu_pkg::CC_V] = (opnd0[7] == opnd1[7]) && (rslt[7] != opnd0[7]);
            end
            kcpu_pkg::ALU_SUB: begin
                sum  = {1'b0, opnd0} - {1'b0, opnd1};
                rslt = sum[7:0];
                cc_out[kcpu_pkg::CC_C] = sum[8];   // Borrow
                cc_out[kcpu_pkg::CC_V] = (opnd0[7] != opnd1[7]) && (rslt[7] != opnd0[7]);
            end
            kcpu_pkg::ALU_AND: begin
                rslt = opnd0 & opnd1;
                cc_out[kcpu_pkg::CC_V] = 1'b0;
            end
            default: begin
                cc_out[kcpu_pkg::CC_V] = 1'b0;  // Loads clear V
            end
        endcase
        cc_out[kcpu_pkg::CC_N] = rslt[7];
        cc_out[kcpu_pkg::CC_Z] = rslt == 8'h00;
    end

endmodule

// ==== verilog/kcpu_regs.sv ====
module kcpu_regs (
    input  logic            clk,
    input  logic            reset,
    input  logic            cen,
    input  kcpu_pkg::ctrl_t ctrl,
    input  kcpu_pkg::mem_t  mem,
    input  kcpu_pkg::byte_t rslt,
    input  kcpu_pkg::byte_t cc_out,
    output kcpu_pkg::byte_t a,
    output kcpu_pkg::byte_t b,
    output kcpu_pkg::byte_t cc,
    output kcpu_pkg::word_t x,
    output kcpu_pkg::word_t pc,
    output kcpu_pkg::byte_t opnd0
);

    kcpu_pkg::word_t pc_nx;
    kcpu_pkg::word_t rel;

    assign pc_nx = pc + {15'd0, ctrl.inc_pc};
    assign rel   = {{8{rslt[7]}}, rslt};  // Branch offset passes through the ALU

    // Accumulator in use for this instruction
    assign opnd0 = ctrl.up_b ? b : a;

    always_ff @(posedge clk) begin
        if (reset) begin
            a  <= '0;
            b  <= '0;
            cc <= '0;
            x  <= '0;
            pc <= '0;
        end else if (cen) begin
            if (ctrl.up_a)  a  <= rslt;
            if (ctrl.up_b)  b  <= rslt;
            if (ctrl.up_cc) cc <= cc_out;

            if (ctrl.up_x) begin
                x <= {mem.mdata_hi, rslt};
            end else if (ctrl.incx) begin
                x <= x + 16'd1;           // Post-increment after the access
            end

            // Offset is relative to the byte after the branch
            if (ctrl.branch) begin
                pc <= pc_nx + rel;
            end else begin
                pc <= pc_nx;
            end
        end
    end

endmodule

// ==== verilog/kcpu_memctrl.sv ====
module kcpu_memctrl (
    input  logic            clk,
    input  logic            reset,
    input  logic            cen,
    input  kcpu_pkg::ctrl_t ctrl,
    input  kcpu_pkg::word_t pc,
    input  kcpu_pkg::word_t x,
    input  kcpu_pkg::byte_t a,
    input  kcpu_pkg::byte_t b,
    input  kcpu_pkg::byte_t din,
    output kcpu_pkg::word_t addr,
    output kcpu_pkg::byte_t dout,
    output logic            we,
    output kcpu_pkg::mem_t  mem
);

    kcpu_pkg::byte_t op_q;
    kcpu_pkg::byte_t hi_q, lo_q;

    // Address source for the current bus cycle
    always_comb begin
        case (ctrl.asel)
            kcpu_pkg::AS_EXT: addr = {hi_q, lo_q};
            kcpu_pkg::AS_X:   addr = x;
            default:          addr = pc;
        endcase
    end

    assign dout = ctrl.src_b ? b : a;
    assign we   = ctrl.we;         // Held for the whole step

    // Opcode drives decode
    always_ff @(posedge clk) begin
        if (reset) begin
            op_q <= '0;
        end else if (cen && ctrl.fetch) begin
            op_q <= din;
        end
    end

    // Operand bytes, high one arrives first
    always_ff @(posedge clk) begin
        if (cen) begin
            if (ctrl.opd)    hi_q <= din;
            if (ctrl.opd_lo) lo_q <= din;
        end
    end

    always_comb begin
        mem.op       = op_q;
        mem.mdata_hi = hi_q;
        mem.mdata_lo = lo_q;
    end

endmodule

// ==== verilog/kcpu_ctrl.sv ====
module kcpu_ctrl (
    input  logic            clk,
    input  logic            reset,
    input  logic            cen,
    input  logic            halt,
    input  kcpu_pkg::mem_t  mem,
    input  kcpu_pkg::byte_t cc,
    input  kcpu_pkg::word_t pc,
    output kcpu_pkg::ctrl_t ctrl,
    output logic            buserror,
    output kcpu_pkg::word_t pcbad
);

    kcpu_pkg::cpu_state_e state, nx_state;
    kcpu_pkg::alu_op_e    imm_alu;
    logic                 take;

    // Branch condition from the flags
    always_comb begin
        case (mem.op)
            kcpu_pkg::OP_BEQ: take = cc[kcpu_pkg::CC_Z];
            kcpu_pkg::OP_BNE: take = ~cc[kcpu_pkg::CC_Z];
            kcpu_pkg::OP_BCS: take = cc[kcpu_pkg::CC_C];
            default:          take = 1'b1;   // BRA
        endcase
    end

    always_comb begin
        case (mem.op)
            kcpu_pkg::OP_ADDA: imm_alu = kcpu_pkg::ALU_ADD;
            kcpu_pkg::OP_SUBA: imm_alu = kcpu_pkg::ALU_SUB;
            kcpu_pkg::OP_ANDA: imm_alu = kcpu_pkg::ALU_AND;
            default:           imm_alu = kcpu_pkg::ALU_PASS;
        endcase
    end

    always_comb begin
        ctrl     = '0;             // Bus at PC, read, ALU pass
        nx_state = state;
        case (state)
            kcpu_pkg::ST_FETCH: begin
                if (!halt) begin
                    ctrl.fetch  = 1'b1;
                    ctrl.inc_pc = 1'b1;
                    nx_state    = kcpu_pkg::ST_OPND;
                end
            end
            kcpu_pkg::ST_OPND: begin
                nx_state = kcpu_pkg::ST_FETCH;
                case (mem.op)
                    // This step is already the next fetch
                    kcpu_pkg::OP_NOP: begin
                        if (!halt) begin
                            ctrl.fetch  = 1'b1;
                            ctrl.inc_pc = 1'b1;
                            nx_state    = kcpu_pkg::ST_OPND;
                        end
                    end
                    kcpu_pkg::OP_LDA_IMM, kcpu_pkg::OP_ADDA,
                    kcpu_pkg::OP_SUBA, kcpu_pkg::OP_ANDA: begin
                        ctrl.inc_pc = 1'b1;
                        ctrl.alu_op = imm_alu;
                        ctrl.up_a   = 1'b1;
                        ctrl.up_cc  = 1'b1;
                    end
                    kcpu_pkg::OP_LDB_IMM: begin
                        ctrl.inc_pc = 1'b1;
                        ctrl.up_b   = 1'b1;
                        ctrl.up_cc  = 1'b1;
                    end
                    kcpu_pkg::OP_LDX_IMM, kcpu_pkg::OP_LDA_EXT,
                    kcpu_pkg::OP_STA_EXT, kcpu_pkg::OP_STB_EXT: begin
                        ctrl.inc_pc = 1'b1;
                        ctrl.opd    = 1'b1;
                        nx_state    = kcpu_pkg::ST_OPND_LO;
                    end
                    kcpu_pkg::OP_LDA_IDX: begin
                        ctrl.asel  = kcpu_pkg::AS_X;
                        ctrl.up_a  = 1'b1;
                        ctrl.up_cc = 1'b1;
                        ctrl.incx  = 1'b1;
                    end
                    kcpu_pkg::OP_STA_IDX: begin
                        ctrl.asel = kcpu_pkg::AS_X;
                        ctrl.we   = 1'b1;
                        ctrl.incx = 1'b1;
                    end
                    kcpu_pkg::OP_BRA, kcpu_pkg::OP_BEQ,
                    kcpu_pkg::OP_BNE, kcpu_pkg::OP_BCS: begin
                        ctrl.inc_pc = 1'b1;
                        ctrl.branch = take;
                    end
                    default: nx_state = kcpu_pkg::ST_TRAP;
                endcase
            end
            kcpu_pkg::ST_OPND_LO: begin
                ctrl.inc_pc = 1'b1;
                ctrl.opd_lo = 1'b1;
                if (mem.op == kcpu_pkg::OP_LDX_IMM) begin
                    ctrl.up_x = 1'b1;      // High byte already captured
                    nx_state  = kcpu_pkg::ST_FETCH;
                end else if (mem.op == kcpu_pkg::OP_LDA_EXT) begin
                    nx_state = kcpu_pkg::ST_EXEC;
                end else begin
                    nx_state = kcpu_pkg::ST_WRITE;
                end
            end
            kcpu_pkg::ST_EXEC: begin
                ctrl.asel  = kcpu_pkg::AS_EXT;
                ctrl.up_a  = 1'b1;
                ctrl.up_cc = 1'b1;
                nx_state   = kcpu_pkg::ST_FETCH;
            end
            kcpu_pkg::ST_WRITE: begin
                ctrl.asel  = kcpu_pkg::AS_EXT;
                ctrl.we    = 1'b1;
                ctrl.src_b = mem.op == kcpu_pkg::OP_STB_EXT;
                nx_state   = kcpu_pkg::ST_FETCH;
            end
            kcpu_pkg::ST_TRAP: nx_state = kcpu_pkg::ST_TRAP;  // Only reset leaves
            default:           nx_state = kcpu_pkg::ST_FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= kcpu_pkg::ST_FETCH;
            pcbad <= '0;
        end else if (cen) begin
            state <= nx_state;
            // PC already points past the bad opcode
            if (nx_state == kcpu_pkg::ST_TRAP && state != kcpu_pkg::ST_TRAP)
                pcbad <= pc - 16'd1;
        end
    end

    assign buserror = state == kcpu_pkg::ST_TRAP;

endmodule

// ==== verilog/kcpu.sv ====
module kcpu (
    input  logic             clk,
    input  logic             reset,
    input  logic             cen2,
    input  logic             halt,
    input  logic             dtack,
    input  kcpu_pkg::byte_t  din,
    output logic             cen_out,
    output kcpu_pkg::byte_t  dout,
    output kcpu_pkg::baddr_t addr,
    output logic             we,
    output kcpu_pkg::word_t  pcbad,
    output logic             buserror
);

    kcpu_pkg::ctrl_t ctrl;
    kcpu_pkg::mem_t  mem;
    kcpu_pkg::byte_t a, b, cc, rslt, cc_out, opnd0;
    kcpu_pkg::word_t pc, x, core_addr;
    logic            phase;
    logic            cen;

    // Core steps on every other enabled clock, frozen while dtack is low
    always_ff @(posedge clk) begin
        if (reset) begin
            phase   <= 1'b0;
            cen     <= 1'b0;
            cen_out <= 1'b0;
        end else begin
            if (cen2 && dtack) phase <= ~phase;
            cen     <= cen2 & dtack & phase;
            cen_out <= cen2 & dtack;
        end
    end

    assign addr = {8'h00, core_addr};  // No bank register

    kcpu_ctrl u_ctrl (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .cen      ( cen      ),
        .halt     ( halt     ),
        .mem      ( mem      ),
        .cc       ( cc       ),
        .pc       ( pc       ),
        .ctrl     ( ctrl     ),
        .buserror ( buserror ),
        .pcbad    ( pcbad    )
    );

    kcpu_memctrl u_memctrl (
        .clk      ( clk       ),
        .reset    ( reset     ),
        .cen      ( cen       ),
        .ctrl     ( ctrl      ),
        .pc       ( pc        ),
        .x        ( x         ),
        .a        ( a         ),
        .b        ( b         ),
        .din      ( din       ),
        .addr     ( core_addr ),
        .dout     ( dout      ),
        .we       ( we        ),
        .mem      ( mem       )
    );

    // Memory operand goes straight into the ALU so execute can share the read step
    kcpu_alu u_alu (
        .alu_op   ( ctrl.alu_op ),
        .opnd0    ( opnd0       ),
        .opnd1    ( din         ),
        .cc_in    ( cc          ),
        .rslt     ( rslt        ),
        .cc_out   ( cc_out      )
    );

    kcpu_regs u_regs (
        .clk      ( clk     ),
        .reset    ( reset   ),
        .cen      ( cen     ),
        .ctrl     ( ctrl    ),
        .mem      ( mem     ),
        .rslt     ( rslt    ),
        .cc_out   ( cc_out  ),
        .a        ( a       ),
        .b        ( b       ),
        .cc       ( cc      ),
        .x        ( x       ),
        .pc       ( pc      ),
        .opnd0    ( opnd0   )
    );

endmodule

// ==== dv/kcpu_tb.sv ====
module kcpu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD      = 4;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 5000;

    localparam kcpu_pkg::word_t SENT_ADDR  = 16'hff00;  // Last store of each program
    localparam kcpu_pkg::word_t BR_BASE    = 16'h0500;
    localparam kcpu_pkg::word_t SRC_BASE   = 16'h0400;
    localparam kcpu_pkg::byte_t BAD_OP     = 8'h01;
    localparam kcpu_pkg::byte_t MARK_TAKEN = 8'h7e;
    localparam kcpu_pkg::byte_t MARK_SKIP  = 8'h81;
    localparam kcpu_pkg::byte_t V_LDA      = 8'h37;
    localparam kcpu_pkg::byte_t V_EXT      = 8'hc9;
    localparam kcpu_pkg::byte_t V_ADD      = 8'h5e;
    localparam kcpu_pkg::byte_t V_SUB      = 8'hd1;
    localparam kcpu_pkg::byte_t V_AND      = 8'h6f;
    localparam kcpu_pkg::byte_t V_LDB      = 8'ha4;

    logic clk, reset, cen2, halt, dtack;
    logic we, cen_out, buserror;
    kcpu_pkg::byte_t  din, dout;
    kcpu_pkg::baddr_t addr;
    kcpu_pkg::word_t  pcbad;

    kcpu_pkg::byte_t mem [0:65535];
    kcpu_pkg::byte_t exp_mark [0:7];
    kcpu_pkg::word_t pa;            // Program load pointer
    logic [15:0]     lfsr;
    logic            wait_mode;     // Random dtack
    logic            sent_seen;
    int              wr_count;
    int              fails;

    kcpu DUT (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .cen2     ( cen2     ),
        .halt     ( halt     ),
        .dtack    ( dtack    ),
        .din      ( din      ),
        .cen_out  ( cen_out  ),
        .dout     ( dout     ),
        .addr     ( addr     ),
        .we       ( we       ),
        .pcbad    ( pcbad    ),
        .buserror ( buserror )
    );

    assign din = mem[addr[15:0]];

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("Timeout: the run did not finish within its cycle budget");
        $display(">>> FAIL");
        $fatal(1, "watchdog");
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[0] ^ s[2] ^ s[3] ^ s[5];   // x^16 + x^14 + x^13 + x^11
        return {fb, s[15:1]};
    endfunction

    function automatic kcpu_pkg::byte_t fill_value(input kcpu_pkg::word_t a);
        return a[7:0] ^ a[15:8] ^ 8'h5a;
    endfunction

    // Expected branch decision after p - q
    function automatic logic branch_taken(input kcpu_pkg::byte_t op,
                                          input kcpu_pkg::byte_t p, input kcpu_pkg::byte_t q);
        logic z, c;
        z = p == q;
        c = p < q;   // Borrow
        case (op)
            kcpu_pkg::OP_BEQ: return z;
            kcpu_pkg::OP_BNE: return !z;
            kcpu_pkg::OP_BCS: return c;
            default:          return 1'b1;
        endcase
    endfunction

    // Zero ends the block
    function automatic kcpu_pkg::byte_t src_byte(input int i);
        if (i < 7) return 8'(8'h11 * (i + 1));
        else return 8'h00;
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (expected !== actual) begin
            fails++;
            $display("Error %s exp %h got %h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // One clock; bus values are stable here through the next rising edge
    task automatic tick();
        @(negedge clk);
        // Inputs still hold what the last rising edge sampled
        check("cen_out", 32'(cen_out), 32'(!reset && cen2 && dtack));
        if (wait_mode) begin
            dtack = lfsr[0];
            lfsr  = lfsr_next(lfsr);
        end else begin
            dtack = 1'b1;
        end
        if (we && dtack) begin
            mem[addr[15:0]] = dout;
            wr_count++;
            if (addr[15:0] == SENT_ADDR) sent_seen = 1'b1;
        end
    endtask

    task automatic emit(input kcpu_pkg::byte_t v);
        mem[pa] = v;
        pa = pa + 16'd1;
    endtask

    task automatic imm_instr(input kcpu_pkg::byte_t op, input kcpu_pkg::byte_t v);
        emit(op);
        emit(v);
    endtask

    task automatic ext_instr(input kcpu_pkg::byte_t op, input kcpu_pkg::word_t a);
        emit(op);
        emit(a[15:8]);
        emit(a[7:0]);
    endtask

    task automatic end_program();
        ext_instr(kcpu_pkg::OP_STA_EXT, SENT_ADDR);
        imm_instr(kcpu_pkg::OP_BRA, 8'hfe);   // Spin on itself
    endtask

    task automatic begin_load();
        int i;
        tick();
        reset = 1'b1;
        for (i = 0; i < 65536; i++) mem[16'(i)] = fill_value(16'(i));
        pa        = 16'h0000;
        sent_seen = 1'b0;
    endtask

    task automatic release_reset();
        repeat (16) tick();
        reset = 1'b0;
    endtask

    task automatic run_to_sentinel(input int limit);
        int n;
        n = 0;
        while (!sent_seen && n < limit) begin
            tick();
            n++;
        end
        if (!sent_seen) begin
            $display("Program did not reach its final store within %0d cycles", limit);
            $display(">>> FAIL");
            $fatal(1, "stall");
        end
    endtask

    task automatic load_alu_prog();
        mem[16'h0200] = V_EXT;
        emit(kcpu_pkg::OP_NOP);
        imm_instr(kcpu_pkg::OP_LDA_IMM, V_LDA);
        ext_instr(kcpu_pkg::OP_STA_EXT, 16'h0300);
        ext_instr(kcpu_pkg::OP_LDA_EXT, 16'h0200);
        imm_instr(kcpu_pkg::OP_ADDA, V_ADD);
        ext_instr(kcpu_pkg::OP_STA_EXT, 16'h0301);
        imm_instr(kcpu_pkg::OP_SUBA, V_SUB);
        ext_instr(kcpu_pkg::OP_STA_EXT, 16'h0302);
        imm_instr(kcpu_pkg::OP_ANDA, V_AND);
        ext_instr(kcpu_pkg::OP_STA_EXT, 16'h0303);
        imm_instr(kcpu_pkg::OP_LDB_IMM, V_LDB);
        ext_instr(kcpu_pkg::OP_STB_EXT, 16'h0304);
        end_program();
    endtask

    task automatic check_alu_mem();
        kcpu_pkg::byte_t r;
        check("mem[0300]", 32'(mem[16'h0300]), 32'(V_LDA));
        r = V_EXT + V_ADD;
        check("mem[0301]", 32'(mem[16'h0301]), 32'(r));
        r = r - V_SUB;
        check("mem[0302]", 32'(mem[16'h0302]), 32'(r));
        r = r & V_AND;
        check("mem[0303]", 32'(mem[16'h0303]), 32'(r));
        check("mem[0304]", 32'(mem[16'h0304]), 32'(V_LDB));
    endtask

    task automatic emit_branch_case(input logic [2:0] idx, input kcpu_pkg::byte_t op,
                                    input kcpu_pkg::byte_t p, input kcpu_pkg::byte_t q);
        imm_instr(kcpu_pkg::OP_LDA_IMM, p);
        imm_instr(kcpu_pkg::OP_SUBA, q);
        imm_instr(op, 8'h04);                 // Taken skips the next two
        imm_instr(kcpu_pkg::OP_LDB_IMM, MARK_SKIP);
        imm_instr(kcpu_pkg::OP_BRA, 8'h02);
        imm_instr(kcpu_pkg::OP_LDB_IMM, MARK_TAKEN);
        ext_instr(kcpu_pkg::OP_STB_EXT, BR_BASE + {13'd0, idx});
        exp_mark[idx] = branch_taken(op, p, q) ? MARK_TAKEN : MARK_SKIP;
    endtask

    task automatic reset_values();
        begin_load();
        imm_instr(kcpu_pkg::OP_LDA_IMM, 8'h99);
        end_program();
        release_reset();
        check("we", 32'(we), 0);
        check("buserror", 32'(buserror), 0);
        check("addr", 32'(addr), 0);
        run_to_sentinel(200);
    endtask

    task automatic alu_program();
        begin_load();
        load_alu_prog();
        release_reset();
        run_to_sentinel(2000);
        check_alu_mem();
    endtask

    task automatic branch_flags();
        int i;
        kcpu_pkg::word_t a16;
        begin_load();
        emit_branch_case(3'd0, kcpu_pkg::OP_BEQ, 8'h5a, 8'h5a);
        emit_branch_case(3'd1, kcpu_pkg::OP_BEQ, 8'h5a, 8'h5b);
        emit_branch_case(3'd2, kcpu_pkg::OP_BNE, 8'h33, 8'h34);
        emit_branch_case(3'd3, kcpu_pkg::OP_BNE, 8'h33, 8'h33);
        emit_branch_case(3'd4, kcpu_pkg::OP_BCS, 8'h10, 8'h20);
        emit_branch_case(3'd5, kcpu_pkg::OP_BCS, 8'h20, 8'h10);
        emit_branch_case(3'd6, kcpu_pkg::OP_BRA, 8'h01, 8'h02);
        end_program();
        release_reset();
        run_to_sentinel(3000);
        for (i = 0; i < 7; i++) begin
            a16 = BR_BASE + 16'(i);
            check($sformatf("mem[%h]", a16), 32'(mem[a16]), 32'(exp_mark[3'(i)]));
        end
    endtask

    // Source on even bytes and its copy on the odd byte after each
    task automatic indexed_copy();
        int i;
        kcpu_pkg::word_t a16;
        begin_load();
        for (i = 0; i < 8; i++) mem[SRC_BASE + 16'(2 * i)] = src_byte(i);
        ext_instr(kcpu_pkg::OP_LDX_IMM, SRC_BASE);
        emit(kcpu_pkg::OP_LDA_IDX);
        emit(kcpu_pkg::OP_STA_IDX);
        imm_instr(kcpu_pkg::OP_BNE, 8'hfc);    // Back to LDA until a zero byte
        end_program();
        release_reset();
        run_to_sentinel(2000);
        for (i = 0; i < 8; i++) begin
            a16 = SRC_BASE + 16'(2 * i + 1);
            check($sformatf("mem[%h]", a16), 32'(mem[a16]), 32'(src_byte(i)));
        end
    endtask

    task automatic wait_and_halt();
        int k;
        kcpu_pkg::baddr_t held;
        wait_mode = 1'b1;
        begin_load();
        load_alu_prog();
        release_reset();
        for (k = 0; k < 3; k++) begin
            repeat (8 + 5 * k) tick();
            halt = 1'b1;
            repeat (80) tick();                // Current instruction drains
            held = addr;
            repeat (30) begin
                tick();
                check("we", 32'(we), 0);
                check("addr", 32'(addr), 32'(held));
            end
            halt = 1'b0;
        end
        run_to_sentinel(4000);
        check_alu_mem();
        wait_mode = 1'b0;
    endtask

    task automatic illegal_opcode();
        kcpu_pkg::word_t bad_at;
        int writes;
        int n;
        begin_load();
        imm_instr(kcpu_pkg::OP_LDA_IMM, 8'h42);
        ext_instr(kcpu_pkg::OP_STA_EXT, 16'h0310);
        bad_at = pa;
        emit(BAD_OP);
        ext_instr(kcpu_pkg::OP_STA_EXT, 16'h0311);   // Never reached
        release_reset();
        n = 0;
        while (!buserror && n < 2000) begin
            tick();
            n++;
        end
        if (!buserror) begin
            $display("Undefined opcode did not raise buserror");
            $display(">>> FAIL");
            $fatal(1, "no trap");
        end
        check("pcbad", 32'(pcbad), 32'(bad_at));
        check("mem[0310]", 32'(mem[16'h0310]), 32'h42);
        writes = wr_count;
        repeat (100) begin
            tick();
            check("we", 32'(we), 0);
            check("buserror", 32'(buserror), 1);
        end
        check("write count", wr_count, writes);
        check("mem[0311]", 32'(mem[16'h0311]), 32'(fill_value(16'h0311)));
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        cen2      = 1'b1;
        halt      = 1'b0;
        dtack     = 1'b1;
        wait_mode = 1'b0;
        lfsr      = 16'd8;
        sent_seen = 1'b0;
        pa        = 16'h0000;
        wr_count  = 0;
        fails     = 0;
        reset_values();
        alu_program();
        branch_flags();
        indexed_copy();
        wait_and_halt();
        illegal_opcode();
        if (fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
verilog/kcpu_pkg.sv
verilog/kcpu_alu.sv
verilog/kcpu_regs.sv
verilog/kcpu_memctrl.sv
verilog/kcpu_ctrl.sv
verilog/kcpu.sv
dv/kcpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the kcpu testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module kcpu_tb -f vlog.f -o kcpu_sim &&
./obj_dir/kcpu_sim | tee /dev/stderr | grep -F -q '>>> PASS' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
